// ==== logic/dodge_config.svh ====
`ifndef DODGE_CONFIG_SVH
`define DODGE_CONFIG_SVH

// Matrix geometry
`define DODGE_ROWS 8
`define DODGE_COLS 8

// Cycles a button must stay put before it counts
`define DODGE_DEBOUNCE_CYCLES 16'd1000

// Step period at level 0, and cycles taken off per level
`define DODGE_STEP_BASE 16'd40000
`define DODGE_STEP_DEC 16'd4000
// Steps per level increment
`define DODGE_LEVEL_STEPS 8'd16

// Obstacle generator start value
`define DODGE_LFSR_SEED 16'hACE1
// Player column after reset and restart
`define DODGE_PLAYER_START 3'd3

// System clocks per half serial clock period
`define DODGE_SCLK_DIV 8'd4
// Display brightness code
`define DODGE_INTENSITY 4'hA

// MAX7219 register addresses
`define MAX_REG_DIGIT0 4'h1
`define MAX_REG_DECODE 4'h9
`define MAX_REG_INTENSITY 4'hA
`define MAX_REG_SCANLIMIT 4'hB
`define MAX_REG_SHUTDOWN 4'hC
`define MAX_REG_TEST 4'hF

`endif

// ==== logic/dodge_pkg.sv ====
`include "dodge_config.svh"

package dodge_pkg;

	// ####################
	// Field types
	// ####################

	// One matrix row, bit c lights column c
	typedef logic [`DODGE_COLS-1:0] row_t;

	// Row address, 0 is the top row
	typedef logic [$clog2(`DODGE_ROWS)-1:0] row_idx_t;

	// Player column on the bottom row
	typedef logic [$clog2(`DODGE_COLS)-1:0] col_t;

	// ####################
	// Game types
	// ####################

	// Difficulty, saturates at 7
	typedef logic [2:0] level_t;

	// Obstacle generator state
	typedef logic [15:0] lfsr_t;

	// Top game FSM
	typedef enum logic [1:0] {IDLE, RUN, OVER} game_state_t;

endpackage

// ==== logic/field_bus_if.sv ====
`timescale 1ns/100ps

// Wishbone classic read channel, display driver to game field
interface field_bus_if;
	import dodge_pkg::*;

	// Row address and returned row
	row_idx_t adr;
	row_t dat_r;
	// Handshake
	logic cyc;
	logic stb;
	logic ack;

	// Display side fetches rows
	modport master (output cyc, output stb, output adr, input ack, input dat_r);

	// Game side answers one cycle later, never stalls
	modport slave (input cyc, input stb, input adr, output ack, output dat_r);

endinterface

// ==== logic/button_debounce.sv ====
`timescale 1ns/100ps
`include "dodge_config.svh"

module button_debounce (
	input  logic clock_50,
	input  logic arst_n,
	input  logic button_n,
	output logic press
);

	// Two flop synchroniser, idles high like the button
	logic [1:0] sync;
	// Last synchronised level seen
	logic level_last;
	// Cycles since the last change
	logic [15:0] stable_cnt;

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			sync <= 2'b11;
			level_last <= 1'b1;
			stable_cnt <= '0;
			press <= 1'b0;
		end else begin
			sync <= {sync[0], button_n};
			// Pulse is one cycle wide
			press <= 1'b0;
			if (sync[1] != level_last) begin
				// Any edge restarts the count
				level_last <= sync[1];
				stable_cnt <= '0;
			end else if (stable_cnt != `DODGE_DEBOUNCE_CYCLES) begin
				stable_cnt <= stable_cnt + 16'd1;
				// Fire once, only for a held low level
				if (stable_cnt == `DODGE_DEBOUNCE_CYCLES - 16'd1 && !level_last) begin
					press <= 1'b1;
				end
			end
		end
	end

	// Count parks at the limit until the next edge,
	// so a long hold gives no second pulse
	// and release only restarts the count

endmodule

// ==== logic/dodge_game.sv ====
`timescale 1ns/100ps
`include "dodge_config.svh"

module dodge_game (
	input  logic clock_50,
	input  logic arst_n,
	input  logic start_press,
	input  logic left_press,
	input  logic right_press,
	field_bus_if.slave bus,
	output logic game_over,
	output dodge_pkg::level_t level
);
	import dodge_pkg::*;

	game_state_t state;
	// Obstacle field, row 0 on top
	row_t field [`DODGE_ROWS];
	col_t player;
	lfsr_t lfsr;
	lfsr_t lfsr_next;
	// Parity of the step count, odd steps insert a gap
	logic odd_step;
	// Steps since the last level change, 1 to LEVEL_STEPS
	logic [7:0] level_cnt;
	// Step timer and current period
	logic [15:0] timer;
	logic [15:0] period;
	logic step;
	// Player dot as a row mask
	row_t player_bit;
	// Row 6 lands on the player with this step
	logic hit;

	// ####################
	// Step timing
	// ####################

	// Period shrinks by one decrement per level
	assign period = `DODGE_STEP_BASE - 16'(level) * `DODGE_STEP_DEC;
	assign step = (state == RUN) && (timer == period - 16'd1);

	// Fibonacci taps 16,14,13,11, feedback enters bit 0
	assign lfsr_next = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};

	assign player_bit = row_t'(1'b1) << player;
	// Row 7 after the shift is the current row 6
	assign hit = |(field[`DODGE_ROWS-2] & player_bit);

	// OVER holds the frozen field
	assign game_over = (state == OVER);

	// ####################
	// Game FSM
	// ####################

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			player <= `DODGE_PLAYER_START;
			lfsr <= `DODGE_LFSR_SEED;
			odd_step <= 1'b0;
			level_cnt <= '0;
			level <= '0;
			timer <= '0;
			for (int r = 0; r < `DODGE_ROWS; r++) begin
				field[r] <= '0;
			end
		end else begin
			case (state)
				IDLE: begin
					if (start_press) begin
						// Fresh period on entry to RUN
						state <= RUN;
						timer <= '0;
					end
				end
				RUN: begin
					if (step) begin
						timer <= '0;
						// Scroll down one row
						for (int r = `DODGE_ROWS - 1; r > 0; r--) begin
							field[r] <= field[r-1];
						end
						lfsr <= lfsr_next;
						// Even counts take new obstacles
						field[0] <= odd_step ? '0 : lfsr_next[`DODGE_COLS-1:0];
						odd_step <= ~odd_step;
						// Level after step k is k / LEVEL_STEPS
						if (level_cnt == `DODGE_LEVEL_STEPS) begin
							level_cnt <= 8'd1;
							if (level != '1) begin
								level <= level + 3'd1;
							end
						end else begin
							level_cnt <= level_cnt + 8'd1;
						end
						if (hit) begin
							state <= OVER;
						end
					end else begin
						timer <= timer + 16'd1;
					end
				end
				OVER: begin
					if (start_press) begin
						// Back to a clean idle board
						state <= IDLE;
						player <= `DODGE_PLAYER_START;
						lfsr <= `DODGE_LFSR_SEED;
						odd_step <= 1'b0;
						level_cnt <= '0;
						level <= '0;
						for (int r = 0; r < `DODGE_ROWS; r++) begin
							field[r] <= '0;
						end
					end
				end
				default: state <= IDLE;
			endcase

			// Player moves, saturating at the edges
			if (state != OVER) begin
				if (left_press && player != '0) begin
					player <= player - col_t'(1);
				end else if (right_press && player != '1) begin
					player <= player + col_t'(1);
				end
			end
		end
	end

	// ####################
	// Wishbone slave
	// ####################

	// Single cycle ack, one cycle after the request
	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			bus.ack <= 1'b0;
		end else begin
			bus.ack <= bus.cyc && bus.stb && !bus.ack;
		end
	end

	// Bottom row shows the player dot on top of the field
	always_ff @(posedge clock_50) begin
		if (bus.cyc && bus.stb) begin
			if (bus.adr == row_idx_t'(`DODGE_ROWS - 1)) begin
				bus.dat_r <= field[bus.adr] | player_bit;
			end else begin
				bus.dat_r <= field[bus.adr];
			end
		end
	end

endmodule

// ==== logic/max7219_driver.sv ====
`timescale 1ns/100ps
`include "dodge_config.svh"

module max7219_driver (
	input  logic clock_50,
	input  logic arst_n,
	field_bus_if.master bus,
	output logic din,
	output logic ncs,
	output logic clk
);
	import dodge_pkg::*;

	// Frame sequencer
	typedef enum logic [2:0] {PREP, FETCH, START, SHIFT, STOP, GAP} drv_state_t;

	drv_state_t state;
	// Serial clock divider
	logic [7:0] div_cnt;
	logic tick;
	// Init frames first, then endless refresh
	logic in_init;
	logic [2:0] init_idx;
	row_idx_t row_idx;
	logic [3:0] init_code;
	logic [7:0] init_data;
	logic [3:0] digit_code;
	// Outgoing frame, MSB first
	logic [15:0] shift;
	logic [3:0] bit_cnt;
	// Bus request
	logic req;

	assign bus.cyc = req;
	assign bus.stb = req;
	assign bus.adr = row_idx;

	// Half period tick, free running
	assign tick = (div_cnt == `DODGE_SCLK_DIV - 8'd1);

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= tick ? 8'd0 : div_cnt + 8'd1;
		end
	end

	// ####################
	// Init table
	// ####################

	always_comb begin
		case (init_idx)
			3'd0: begin init_code = `MAX_REG_SHUTDOWN; init_data = 8'h01; end
			3'd1: begin init_code = `MAX_REG_SCANLIMIT; init_data = 8'h07; end
			3'd2: begin init_code = `MAX_REG_DECODE; init_data = 8'h00; end
			3'd3: begin init_code = `MAX_REG_INTENSITY; init_data = {4'h0, `DODGE_INTENSITY}; end
			default: begin init_code = `MAX_REG_TEST; init_data = 8'h00; end
		endcase
	end

	// Row r goes to digit register r + 1
	assign digit_code = `MAX_REG_DIGIT0 + {1'b0, row_idx};

	// ####################
	// Frame FSM
	// ####################

	always_ff @(posedge clock_50 or negedge arst_n) begin
		if (!arst_n) begin
			state <= PREP;
			in_init <= 1'b1;
			init_idx <= '0;
			row_idx <= '0;
			req <= 1'b0;
			shift <= '0;
			bit_cnt <= '0;
			ncs <= 1'b1;
			clk <= 1'b0;
			din <= 1'b0;
		end else begin
			case (state)
				PREP: begin
					if (in_init) begin
						shift <= {4'h0, init_code, init_data};
						state <= START;
					end else begin
						req <= 1'b1;
						state <= FETCH;
					end
				end
				FETCH: begin
					// Row valid together with ack
					if (bus.ack) begin
						req <= 1'b0;
						shift <= {4'h0, digit_code, bus.dat_r};
						state <= START;
					end
				end
				START: begin
					// Select chip and present the first bit
					if (tick) begin
						ncs <= 1'b0;
						din <= shift[15];
						bit_cnt <= '0;
						state <= SHIFT;
					end
				end
				SHIFT: begin
					if (tick) begin
						if (!clk) begin
							// Chip samples here
							clk <= 1'b1;
						end else begin
							clk <= 1'b0;
							if (bit_cnt == 4'd15) begin
								state <= STOP;
							end else begin
								// Next bit while clk is low
								bit_cnt <= bit_cnt + 4'd1;
								shift <= {shift[14:0], 1'b0};
								din <= shift[14];
							end
						end
					end
				end
				STOP: begin
					// Rising ncs latches the frame
					if (tick) begin
						ncs <= 1'b1;
						din <= 1'b0;
						state <= GAP;
					end
				end
				GAP: begin
					if (tick) begin
						if (in_init) begin
							if (init_idx == 3'd4) begin
								in_init <= 1'b0;
							end
							init_idx <= init_idx + 3'd1;
						end else begin
							// Wraps from row 7 to row 0
							row_idx <= row_idx + row_idx_t'(1);
						end
						state <= PREP;
					end
				end
				default: state <= PREP;
			endcase
		end
	end

endmodule

// ==== logic/dodge_top.sv ====
`timescale 1ns/100ps

module dodge_top (
	input  logic clock_50,
	input  logic arst_n,
	input  logic start_button_n,
	input  logic left_button_n,
	input  logic right_button_n,
	output logic max7219_din,
	output logic max7219_ncs,
	output logic max7219_clk,
	output logic game_over,
	output dodge_pkg::level_t level
);

	// Debounced press pulses
	logic start_press;
	logic left_press;
	logic right_press;

	// Row fetch channel, driver to game
	field_bus_if field_bus ();

	// ####################
	// Buttons
	// ####################

	button_debounce start_debounce (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.button_n (start_button_n),
		.press    (start_press)
	);

	button_debounce left_debounce (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.button_n (left_button_n),
		.press    (left_press)
	);

	button_debounce right_debounce (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.button_n (right_button_n),
		.press    (right_press)
	);

	// ####################
	// Game and display
	// ####################

	dodge_game game (
		.clock_50    (clock_50),
		.arst_n      (arst_n),
		.start_press (start_press),
		.left_press  (left_press),
		.right_press (right_press),
		.bus         (field_bus.slave),
		.game_over   (game_over),
		.level       (level)
	);

	max7219_driver driver (
		.clock_50 (clock_50),
		.arst_n   (arst_n),
		.bus      (field_bus.master),
		.din      (max7219_din),
		.ncs      (max7219_ncs),
		.clk      (max7219_clk)
	);

endmodule

// ==== test/dodge_tb.sv ====
`timescale 1ns/100ps
`include "dodge_config.svh"

module dodge_tb;
	import dodge_pkg::*;

	localparam int BTN_START = 0;
	localparam int BTN_LEFT = 1;
	localparam int BTN_RIGHT = 2;
	// Generous bounds for one frame and one refresh pass
	localparam int FRAME_LIMIT = 2 * (40 * int'(`DODGE_SCLK_DIV) + 40);
	localparam int PASS_LIMIT = `DODGE_ROWS * FRAME_LIMIT;
	localparam int DIGIT0 = int'(`MAX_REG_DIGIT0);
	localparam int RESTART_ROWS = 5;

	logic clock_50;
	logic arst_n;
	logic start_button_n;
	logic left_button_n;
	logic right_button_n;
	logic max7219_din;
	logic max7219_ncs;
	logic max7219_clk;
	logic game_over;
	level_t level;

	integer seed;
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	bit timed_out = 1'b0;

	// Decoder state
	logic [15:0] rx_shift = '0;
	int rx_bits = 0;
	int frame_count = 0;
	int pass_count = 0;
	logic [15:0] first_frames [5];
	row_t shadow [`DODGE_ROWS];
	// Row 0 history with repeats collapsed
	bit rec_on = 1'b0;
	row_t rec_rows [$];

	// Game model
	row_t model_field [`DODGE_ROWS];
	lfsr_t model_lfsr;
	int model_steps;
	col_t model_player;
	row_t model_rows [$];
	row_t exp_rows [`DODGE_ROWS];

	dodge_top dodge_top_i (
		.clock_50       (clock_50),
		.arst_n         (arst_n),
		.start_button_n (start_button_n),
		.left_button_n  (left_button_n),
		.right_button_n (right_button_n),
		.max7219_din    (max7219_din),
		.max7219_ncs    (max7219_ncs),
		.max7219_clk    (max7219_clk),
		.game_over      (game_over),
		.level          (level)
	);

	initial begin
		clock_50 = 1'b0;
		forever #5 clock_50 = ~clock_50;
	end

	// ####################
	// Serial decoder
	// ####################

	// Chip samples din on rising clk
	always @(posedge max7219_clk) begin
		if (!max7219_ncs) begin
			rx_shift = {rx_shift[14:0], max7219_din};
			rx_bits = rx_bits + 1;
		end
	end

	// Rising ncs closes the frame
	always @(posedge max7219_ncs) begin
		if (arst_n) begin
			if (rx_bits != 16) begin
				$display("Frame %0d carried %0d bits instead of 16", frame_count, rx_bits);
				errors++;
			end
			store_frame(rx_shift);
		end
		rx_bits = 0;
	end

	task automatic store_frame(input logic [15:0] f);
		row_t data;
		int code;
		data = f[7:0];
		code = int'(f[11:8]);
		if (frame_count < 5) begin
			first_frames[frame_count] = f;
		end
		frame_count++;
		// Digit registers hold the rows
		if (code >= DIGIT0 && code < DIGIT0 + `DODGE_ROWS) begin
			shadow[code - DIGIT0] = data;
			if (code == DIGIT0 && rec_on) begin
				if (rec_rows.size() == 0 || rec_rows[$] != data) begin
					rec_rows.push_back(data);
				end
			end
			// Bottom row ends a refresh pass
			if (code == DIGIT0 + `DODGE_ROWS - 1) begin
				pass_count++;
			end
		end
	endtask

	// ####################
	// Game model
	// ####################

	// Fibonacci taps 16,14,13,11 into bit 0
	function automatic lfsr_t lfsr_advance(input lfsr_t s);
		logic fb;
		fb = s[15] ^ s[13] ^ s[12] ^ s[10];
		return {s[14:0], fb};
	endfunction

	task automatic model_reset();
		for (int r = 0; r < `DODGE_ROWS; r++) begin
			model_field[r] = '0;
		end
		model_lfsr = `DODGE_LFSR_SEED;
		model_steps = 0;
		model_rows.delete();
		model_rows.push_back(8'h00);
	endtask

	task automatic model_step(output bit hit);
		for (int r = `DODGE_ROWS - 1; r > 0; r--) begin
			model_field[r] = model_field[r-1];
		end
		model_lfsr = lfsr_advance(model_lfsr);
		// Even step counts bring obstacles, odd ones a gap
		model_field[0] = (model_steps % 2 == 0) ? model_lfsr[7:0] : 8'h00;
		model_steps++;
		if (model_rows[$] != model_field[0]) begin
			model_rows.push_back(model_field[0]);
		end
		hit = |(model_field[`DODGE_ROWS-1] & row_t'(1 << model_player));
	endtask

	// ####################
	// Helpers
	// ####################

	task automatic report_mismatch(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		$display("[ERROR] %s: got 0x%h expected 0x%h", name, got, exp);
		errors++;
	endtask

	task automatic close_test(input string name, input int errs_before);
		tests_run++;
		if (errors != errs_before || timed_out) begin
			tests_failed++;
			$display("Test %s: failed", name);
		end else begin
			$display("Test %s: ok", name);
		end
	endtask

	task automatic drive_button(input int which, input logic value);
		case (which)
			BTN_START: start_button_n <= value;
			BTN_LEFT: left_button_n <= value;
			default: right_button_n <= value;
		endcase
	endtask

	// Hold always outlasts the debounce time
	task automatic press_button(input int which);
		int hold;
		hold = int'(`DODGE_DEBOUNCE_CYCLES) + 10 + ($random(seed) & 63);
		@(posedge clock_50);
		drive_button(which, 1'b0);
		repeat (hold) @(posedge clock_50);
		drive_button(which, 1'b1);
		repeat (int'(`DODGE_DEBOUNCE_CYCLES) + 10) @(posedge clock_50);
	endtask

	task automatic wait_frames(input int n);
		int cycles;
		cycles = 0;
		while (frame_count < n && !timed_out) begin
			@(posedge clock_50);
			cycles++;
			if (cycles > (n + 1) * FRAME_LIMIT) begin
				$display("Timeout waiting for %0d display frames", n);
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic wait_passes(input int n);
		int target;
		int cycles;
		target = pass_count + n;
		cycles = 0;
		while (pass_count < target && !timed_out) begin
			@(posedge clock_50);
			cycles++;
			if (cycles > (n + 1) * PASS_LIMIT) begin
				$display("Timeout waiting for %0d refresh passes", n);
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic wait_game_over(input logic value, input int limit);
		int cycles;
		cycles = 0;
		while (game_over !== value && !timed_out) begin
			@(posedge clock_50);
			cycles++;
			if (cycles > limit) begin
				$display("Timeout waiting for game_over to become %0b", value);
				timed_out = 1'b1;
			end
		end
	endtask

	task automatic wait_rows(input int n, input int limit);
		int cycles;
		cycles = 0;
		while (rec_rows.size() < n && !timed_out) begin
			@(posedge clock_50);
			cycles++;
			if (cycles > limit) begin
				$display("Timeout waiting for %0d distinct top rows", n);
				timed_out = 1'b1;
			end
		end
	endtask

	// Empty board with only the player dot
	task automatic expect_idle(input col_t col);
		for (int r = 0; r < `DODGE_ROWS; r++) begin
			exp_rows[r] = 8'h00;
		end
		exp_rows[`DODGE_ROWS-1] = row_t'(1 << col);
	endtask

	task automatic compare_display();
		for (int r = 0; r < `DODGE_ROWS; r++) begin
			if (shadow[r] !== exp_rows[r]) begin
				report_mismatch($sformatf("row %0d", r), 16'(shadow[r]), 16'(exp_rows[r]));
			end
		end
	endtask

	task automatic move_burst(input int which, input int count);
		for (int i = 0; i < count; i++) begin
			press_button(which);
			if (which == BTN_LEFT && model_player != col_t'(0)) begin
				model_player = model_player - col_t'(1);
			end else if (which == BTN_RIGHT && model_player != col_t'(7)) begin
				model_player = model_player + col_t'(1);
			end
		end
		wait_passes(2);
		expect_idle(model_player);
		compare_display();
	endtask

	// ####################
	// Tests
	// ####################

	task automatic test_init();
		int e0;
		logic [15:0] exp_frame [5];
		e0 = errors;
		exp_frame[0] = {4'h0, `MAX_REG_SHUTDOWN, 8'h01};
		exp_frame[1] = {4'h0, `MAX_REG_SCANLIMIT, 8'h07};
		exp_frame[2] = {4'h0, `MAX_REG_DECODE, 8'h00};
		exp_frame[3] = {4'h0, `MAX_REG_INTENSITY, 4'h0, `DODGE_INTENSITY};
		exp_frame[4] = {4'h0, `MAX_REG_TEST, 8'h00};
		wait_frames(5);
		for (int i = 0; i < 5; i++) begin
			if (first_frames[i] !== exp_frame[i]) begin
				report_mismatch($sformatf("init frame %0d", i), first_frames[i], exp_frame[i]);
			end
		end
		if (game_over !== 1'b0) begin
			report_mismatch("game_over", 16'(game_over), 16'h0);
		end
		if (level !== level_t'(0)) begin
			report_mismatch("level", 16'(level), 16'h0);
		end
		close_test("init", e0);
	endtask

	task automatic test_idle();
		int e0;
		e0 = errors;
		wait_passes(2);
		model_player = `DODGE_PLAYER_START;
		expect_idle(model_player);
		compare_display();
		close_test("idle display", e0);
	endtask

	task automatic test_move();
		int e0;
		e0 = errors;
		// Left into the wall, right into the wall, then back a little
		move_burst(BTN_LEFT, 4 + ($random(seed) & 3));
		move_burst(BTN_RIGHT, 8 + ($random(seed) & 3));
		move_burst(BTN_LEFT, 1 + ($random(seed) & 3));
		close_test("player movement", e0);
	endtask

	task automatic test_scroll();
		int e0;
		int n;
		bit hit;
		e0 = errors;
		model_reset();
		hit = 1'b0;
		while (!hit && model_steps < 400) begin
			model_step(hit);
		end
		if (!hit) begin
			$display("Model reached no collision within %0d steps", model_steps);
			errors++;
		end
		rec_rows.delete();
		rec_on = 1'b1;
		press_button(BTN_START);
		wait_game_over(1'b1, (model_steps + 4) * int'(`DODGE_STEP_BASE));
		// Top row from the last step reaches the display only after a refetch
		wait_passes(2);
		rec_on = 1'b0;
		if (rec_rows.size() != model_rows.size()) begin
			report_mismatch("top row history length", 16'(rec_rows.size()),
				16'(model_rows.size()));
		end
		n = (rec_rows.size() < model_rows.size()) ? rec_rows.size() : model_rows.size();
		for (int i = 0; i < n; i++) begin
			if (rec_rows[i] !== model_rows[i]) begin
				report_mismatch($sformatf("top row %0d", i), 16'(rec_rows[i]),
					16'(model_rows[i]));
			end
		end
		close_test("scrolling", e0);
	endtask

	task automatic test_collision();
		int e0;
		int exp_level;
		e0 = errors;
		wait_passes(2);
		for (int r = 0; r < `DODGE_ROWS; r++) begin
			exp_rows[r] = model_field[r];
		end
		exp_rows[`DODGE_ROWS-1] = model_field[`DODGE_ROWS-1] | row_t'(1 << model_player);
		compare_display();
		// First step is count 0
		exp_level = (model_steps - 1) / int'(`DODGE_LEVEL_STEPS);
		if (exp_level > 7) begin
			exp_level = 7;
		end
		if (level !== level_t'(exp_level)) begin
			report_mismatch("level", 16'(level), 16'(exp_level));
		end
		if (game_over !== 1'b1) begin
			report_mismatch("game_over", 16'(game_over), 16'h1);
		end
		close_test("collision", e0);
	endtask

	task automatic test_restart();
		int e0;
		bit hit;
		e0 = errors;
		press_button(BTN_START);
		wait_game_over(1'b0, 4 * int'(`DODGE_DEBOUNCE_CYCLES) + 1000);
		model_player = `DODGE_PLAYER_START;
		wait_passes(2);
		expect_idle(model_player);
		compare_display();
		if (level !== level_t'(0)) begin
			report_mismatch("level", 16'(level), 16'h0);
		end
		// Reloaded seed gives the same opening rows
		model_reset();
		while (model_rows.size() < RESTART_ROWS && model_steps < 40) begin
			model_step(hit);
		end
		rec_rows.delete();
		rec_on = 1'b1;
		press_button(BTN_START);
		wait_rows(RESTART_ROWS, (model_steps + 4) * int'(`DODGE_STEP_BASE));
		rec_on = 1'b0;
		for (int i = 0; i < RESTART_ROWS && i < rec_rows.size(); i++) begin
			if (rec_rows[i] !== model_rows[i]) begin
				report_mismatch($sformatf("restart top row %0d", i), 16'(rec_rows[i]),
					16'(model_rows[i]));
			end
		end
		close_test("restart", e0);
	endtask

	// ####################
	// Main sequence
	// ####################

	initial begin
		seed = 86842;
		for (int r = 0; r < `DODGE_ROWS; r++) begin
			shadow[r] = '0;
		end
		arst_n = 1'b0;
		start_button_n = 1'b1;
		left_button_n = 1'b1;
		right_button_n = 1'b1;
		repeat (2) @(posedge clock_50);
		arst_n <= 1'b1;

		test_init();
		if (!timed_out) test_idle();
		if (!timed_out) test_move();
		if (!timed_out) test_scroll();
		if (!timed_out) test_collision();
		if (!timed_out) test_restart();

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0 && !timed_out) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+logic
logic/dodge_pkg.sv
logic/field_bus_if.sv
logic/button_debounce.sv
logic/dodge_game.sv
logic/max7219_driver.sv
logic/dodge_top.sv
test/dodge_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := dodge_tb
FILELIST  := all.f
VFLAGS    := --binary --timing --timescale 1ns/100ps
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log

SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "TB PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
